//--- adc_frontend.sv
// ADC channel with input register, format conversion, loopback mux and calibration
`timescale 1ns/1ps

module adc_frontend (
  input  logic                          adc_clk,
  input  logic                          top_rst,
  input  logic [rp_cfg_pkg::DAT_W-1:0]  raw_i,
  input  logic                          loop_i,
  input  rp_cfg_pkg::smp_t              loop_dat_i,
  input  rp_cfg_pkg::mul_t              mul_i,
  input  rp_cfg_pkg::sum_t              sum_i,
  output rp_cfg_pkg::smp_t              dat_o
);
  import rp_cfg_pkg::*;

  smp_t pin_dat;
  smp_t mux_dat;
  smp_t dat_r;

  // Negative slope offset binary to two's complement
  assign pin_dat = smp_t'(neg_slope(raw_i));
  // Digital loopback takes the calibrated DAC sample
  assign mux_dat = loop_i ? loop_dat_i : pin_dat;

  // Input register, first pipeline stage
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dat_r <= '0;
    end else begin
      dat_r <= mux_dat;
    end
  end

  linear_cal u_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (dat_r),
    .mul_i   (mul_i),
    .sum_i   (sum_i),
    .dat_o   (dat_o)
  );

endmodule : adc_frontend

//--- calib_regs.sv
// Calibration register block with gain and offset per ADC and DAC channel
`timescale 1ns/1ps

module calib_regs (
  sys_bus_if.slave                                    bus,
  input  logic                                        adc_clk,
  input  logic                                        top_rst,
  output rp_cfg_pkg::mul_t [rp_cfg_pkg::CHN_NUM-1:0]  adc_mul_o,
  output rp_cfg_pkg::sum_t [rp_cfg_pkg::CHN_NUM-1:0]  adc_sum_o,
  output rp_cfg_pkg::mul_t [rp_cfg_pkg::CHN_NUM-1:0]  dac_mul_o,
  output rp_cfg_pkg::sum_t [rp_cfg_pkg::CHN_NUM-1:0]  dac_sum_o
);
  import rp_cfg_pkg::*;
  import rp_bus_pkg::*;

  cal_reg_e          offs;
  logic              offs_ok;
  logic [DATA_W-1:0] rd_val;
  mul_t              wr_mul;
  sum_t              wr_sum;

  assign offs = cal_reg_e'(bus.addr[REGION_LSB-1:0]);
  // Gains from the low MUL_W bits, offsets from the low SUM_W bits
  assign wr_mul = mul_t'(bus.wdata[MUL_W-1:0]);
  assign wr_sum = sum_t'(bus.wdata[SUM_W-1:0]);

  // Read mux, all values sign-extended
  always_comb begin
    rd_val  = '0;
    offs_ok = 1'b1;
    case (offs)
      CAL_ADC0_MUL: rd_val = DATA_W'(adc_mul_o[0]);
      CAL_ADC0_SUM: rd_val = DATA_W'(adc_sum_o[0]);
      CAL_ADC1_MUL: rd_val = DATA_W'(adc_mul_o[1]);
      CAL_ADC1_SUM: rd_val = DATA_W'(adc_sum_o[1]);
      CAL_DAC0_MUL: rd_val = DATA_W'(dac_mul_o[0]);
      CAL_DAC0_SUM: rd_val = DATA_W'(dac_sum_o[0]);
      CAL_DAC1_MUL: rd_val = DATA_W'(dac_mul_o[1]);
      CAL_DAC1_SUM: rd_val = DATA_W'(dac_sum_o[1]);
      default:      offs_ok = 1'b0;
    endcase
  end

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
      bus.rdata <= '0;
      // Unity gain, zero offset
      adc_mul_o <= {CHN_NUM{MUL_UNITY}};
      adc_sum_o <= '0;
      dac_mul_o <= {CHN_NUM{MUL_UNITY}};
      dac_sum_o <= '0;
    end else begin
      bus.ack   <= bus.wen | bus.ren;
      bus.err   <= (bus.wen | bus.ren) & ~offs_ok;
      bus.rdata <= bus.ren ? rd_val : '0;
      if (bus.wen) begin
        case (offs)
          CAL_ADC0_MUL: adc_mul_o[0] <= wr_mul;
          CAL_ADC0_SUM: adc_sum_o[0] <= wr_sum;
          CAL_ADC1_MUL: adc_mul_o[1] <= wr_mul;
          CAL_ADC1_SUM: adc_sum_o[1] <= wr_sum;
          CAL_DAC0_MUL: dac_mul_o[0] <= wr_mul;
          CAL_DAC0_SUM: dac_sum_o[0] <= wr_sum;
          CAL_DAC1_MUL: dac_mul_o[1] <= wr_mul;
          CAL_DAC1_SUM: dac_sum_o[1] <= wr_sum;
          default: ;
        endcase
      end
    end
  end

endmodule : calib_regs

//--- compile.f
rp_cfg_pkg.sv
rp_bus_pkg.sv
sys_bus_if.sv
sys_bus_decoder.sv
housekeeping.sv
calib_regs.sv
linear_cal.sv
adc_frontend.sv
dac_backend.sv
rp_top.sv
rp_top_assert.sv
tb_rp_top.sv

//--- dac_backend.sv
// DAC channel with calibration and registered output format conversion
`timescale 1ns/1ps

module dac_backend (
  input  logic                          adc_clk,
  input  logic                          top_rst,
  input  rp_cfg_pkg::smp_t              set_i,
  input  rp_cfg_pkg::mul_t              mul_i,
  input  rp_cfg_pkg::sum_t              sum_i,
  output rp_cfg_pkg::smp_t              cal_o,
  output logic [rp_cfg_pkg::DAT_W-1:0]  raw_o
);
  import rp_cfg_pkg::*;

  // Setpoint is already in range, saturation happens after calibration
  linear_cal u_cal (
    .adc_clk (adc_clk),
    .top_rst (top_rst),
    .dat_i   (set_i),
    .mul_i   (mul_i),
    .sum_i   (sum_i),
    .dat_o   (cal_o)
  );

  // Output register, back to negative slope offset binary
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      raw_o <= neg_slope('0);
    end else begin
      raw_o <= neg_slope(cal_o);
    end
  end

endmodule : dac_backend

//--- housekeeping.sv
// Housekeeping register block with ID, LED, loopback enable and DAC setpoint registers
`timescale 1ns/1ps

module housekeeping (
  sys_bus_if.slave                                    bus,
  input  logic                                        adc_clk,
  input  logic                                        top_rst,
  output logic [rp_cfg_pkg::LED_W-1:0]                led_o,
  output logic                                        loop_o,
  output rp_cfg_pkg::smp_t [rp_cfg_pkg::CHN_NUM-1:0]  dac_set_o
);
  import rp_cfg_pkg::*;
  import rp_bus_pkg::*;

  hk_reg_e           offs;
  logic              offs_ok;
  logic              bad;
  logic [DATA_W-1:0] rd_val;

  assign offs = hk_reg_e'(bus.addr[REGION_LSB-1:0]);

  // Read mux, also flags unknown offsets
  always_comb begin
    rd_val  = '0;
    offs_ok = 1'b1;
    case (offs)
      HK_ID:   rd_val = HK_ID_VALUE;
      HK_LED:  rd_val = DATA_W'(led_o);
      HK_LOOP: rd_val = DATA_W'(loop_o);
      // Setpoints come back sign-extended
      HK_DAC0: rd_val = DATA_W'(dac_set_o[0]);
      HK_DAC1: rd_val = DATA_W'(dac_set_o[1]);
      default: offs_ok = 1'b0;
    endcase
  end

  // ID is read only
  assign bad = ~offs_ok | (bus.wen & (offs == HK_ID));

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      bus.ack   <= 1'b0;
      bus.err   <= 1'b0;
      bus.rdata <= '0;
      led_o     <= '0;
      loop_o    <= 1'b0;
      dac_set_o <= '0;
    end else begin
      // Response one cycle after the strobe
      bus.ack   <= bus.wen | bus.ren;
      bus.err   <= (bus.wen | bus.ren) & bad;
      bus.rdata <= bus.ren ? rd_val : '0;
      // Write lands on the ack edge, HK_ID and unknowns fall through
      if (bus.wen) begin
        case (offs)
          HK_LED:  led_o <= bus.wdata[LED_W-1:0];
          HK_LOOP: loop_o <= bus.wdata[0];
          HK_DAC0: dac_set_o[0] <= smp_t'(bus.wdata[DAT_W-1:0]);
          HK_DAC1: dac_set_o[1] <= smp_t'(bus.wdata[DAT_W-1:0]);
          default: ;
        endcase
      end
    end
  end

endmodule : housekeeping

//--- linear_cal.sv
// Registered gain and offset stage with saturation to the sample range
`timescale 1ns/1ps

module linear_cal (
  input  logic             adc_clk,
  input  logic             top_rst,
  input  rp_cfg_pkg::smp_t dat_i,
  input  rp_cfg_pkg::mul_t mul_i,
  input  rp_cfg_pkg::sum_t sum_i,
  output rp_cfg_pkg::smp_t dat_o
);
  import rp_cfg_pkg::*;

  // Full product, shifted product, sum with one guard bit
  localparam int unsigned PRD_W = DAT_W + MUL_W;
  localparam int unsigned SHF_W = PRD_W - MUL_FRAC;
  localparam int unsigned ACC_W = SHF_W + 1;
  localparam smp_t SMP_MAX = {1'b0, {(DAT_W-1){1'b1}}};
  localparam smp_t SMP_MIN = {1'b1, {(DAT_W-1){1'b0}}};

  logic signed [PRD_W-1:0] prd;
  logic signed [SHF_W-1:0] shf;
  logic signed [ACC_W-1:0] acc;
  logic                    in_rng;
  smp_t                    sat;

  // Gain, drop fraction bits, then offset
  assign prd = dat_i * mul_i;
  assign shf = SHF_W'(prd >>> MUL_FRAC);
  assign acc = shf + sum_i;

  // In range when all bits above the sample MSB match it
  assign in_rng = (&acc[ACC_W-1:DAT_W-1]) | ~(|acc[ACC_W-1:DAT_W-1]);
  assign sat    = in_rng ? acc[DAT_W-1:0] : (acc[ACC_W-1] ? SMP_MIN : SMP_MAX);

  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      dat_o <= '0;
    end else begin
      dat_o <= sat;
    end
  end

endmodule : linear_cal

//--- rp_bus_pkg.sv
// System-bus widths, region field position, region and register-offset enums, ID constant
package rp_bus_pkg;

  localparam int unsigned ADDR_W = 32;
  localparam int unsigned DATA_W = 32;
  // 3-bit region field starts here, offset lives below it
  localparam int unsigned REGION_LSB = 20;

  // Region number, anything else is unmapped
  typedef enum logic [2:0] {
    REG_HK    = 3'd0,
    REG_CALIB = 3'd1
  } region_e;

  // Housekeeping word offsets
  typedef enum logic [REGION_LSB-1:0] {
    HK_ID   = 20'h00, // read only
    HK_LED  = 20'h04,
    HK_LOOP = 20'h08,
    HK_DAC0 = 20'h0C,
    HK_DAC1 = 20'h10
  } hk_reg_e;

  // Calibration word offsets, gain then offset per channel
  typedef enum logic [REGION_LSB-1:0] {
    CAL_ADC0_MUL = 20'h00,
    CAL_ADC0_SUM = 20'h04,
    CAL_ADC1_MUL = 20'h08,
    CAL_ADC1_SUM = 20'h0C,
    CAL_DAC0_MUL = 20'h10,
    CAL_DAC0_SUM = 20'h14,
    CAL_DAC1_MUL = 20'h18,
    CAL_DAC1_SUM = 20'h1C
  } cal_reg_e;

  // Value returned by HK_ID reads
  localparam logic [DATA_W-1:0] HK_ID_VALUE = 32'h5250_0001;

endpackage : rp_bus_pkg

//--- rp_cfg_pkg.sv
// Data-path widths, channel count, calibration format, sample types and format conversion
package rp_cfg_pkg;

  // Converter channels, ADC and DAC alike
  localparam int unsigned CHN_NUM = 2;
  // Converter sample width
  localparam int unsigned DAT_W = 14;
  // Gain is signed fixed point, 14 fraction bits
  localparam int unsigned MUL_W = 16;
  localparam int unsigned MUL_FRAC = 14;
  // Offset width, signed
  localparam int unsigned SUM_W = 14;
  // Board LED count
  localparam int unsigned LED_W = 8;

  typedef logic signed [DAT_W-1:0] smp_t;
  typedef logic signed [MUL_W-1:0] mul_t;
  typedef logic signed [SUM_W-1:0] sum_t;

  // Gain of 1.0, reset value of every gain register
  localparam mul_t MUL_UNITY = mul_t'(1 << MUL_FRAC);

  // Negative-slope offset binary <-> two's complement
  // Same operation both ways: keep MSB, invert the rest
  function automatic logic [DAT_W-1:0] neg_slope(input logic [DAT_W-1:0] dat);
    return {dat[DAT_W-1], ~dat[DAT_W-2:0]};
  endfunction

endpackage : rp_cfg_pkg

//--- rp_top.sv
// Top level with bus decoder, register blocks and ADC and DAC channel pipelines
`timescale 1ns/1ps

module rp_top (
  input  logic                                                    adc_clk,
  input  logic                                                    top_rst,
  // ADC pins, raw negative slope
  input  logic [rp_cfg_pkg::CHN_NUM-1:0][rp_cfg_pkg::DAT_W-1:0]   adc_dat_i,
  // System bus
  input  logic [rp_bus_pkg::ADDR_W-1:0]                           sys_addr_i,
  input  logic [rp_bus_pkg::DATA_W-1:0]                           sys_wdata_i,
  input  logic                                                    sys_wen_i,
  input  logic                                                    sys_ren_i,
  output logic [rp_bus_pkg::DATA_W-1:0]                           sys_rdata_o,
  output logic                                                    sys_err_o,
  output logic                                                    sys_ack_o,
  // Calibrated ADC stream
  output rp_cfg_pkg::smp_t [rp_cfg_pkg::CHN_NUM-1:0]              adc_dat_o,
  // DAC pins, raw negative slope
  output logic [rp_cfg_pkg::CHN_NUM-1:0][rp_cfg_pkg::DAT_W-1:0]   dac_dat_o,
  output logic [rp_cfg_pkg::LED_W-1:0]                            led_o
);
  import rp_cfg_pkg::*;
  import rp_bus_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // System bus
  //////////////////////////////////////////////////////////////////////

  sys_bus_if #(.AW(ADDR_W), .DW(DATA_W)) host_bus ();
  sys_bus_if #(.AW(ADDR_W), .DW(DATA_W)) hk_bus ();
  sys_bus_if #(.AW(ADDR_W), .DW(DATA_W)) cal_bus ();

  // Pins onto the upstream port
  assign host_bus.addr  = sys_addr_i;
  assign host_bus.wdata = sys_wdata_i;
  assign host_bus.wen   = sys_wen_i;
  assign host_bus.ren   = sys_ren_i;
  assign sys_rdata_o    = host_bus.rdata;
  assign sys_err_o      = host_bus.err;
  assign sys_ack_o      = host_bus.ack;

  // Register outputs and DAC loopback samples
  logic                  loop_en;
  smp_t [CHN_NUM-1:0]    dac_set;
  smp_t [CHN_NUM-1:0]    dac_cal;
  mul_t [CHN_NUM-1:0]    adc_mul;
  sum_t [CHN_NUM-1:0]    adc_sum;
  mul_t [CHN_NUM-1:0]    dac_mul;
  sum_t [CHN_NUM-1:0]    dac_sum;

  sys_bus_decoder u_dec (
    .host_bus (host_bus.slave),
    .hk_bus   (hk_bus.master),
    .cal_bus  (cal_bus.master),
    .adc_clk  (adc_clk),
    .top_rst  (top_rst)
  );

  housekeeping u_hk (
    .bus       (hk_bus.slave),
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .led_o     (led_o),
    .loop_o    (loop_en),
    .dac_set_o (dac_set)
  );

  calib_regs u_calib (
    .bus       (cal_bus.slave),
    .adc_clk   (adc_clk),
    .top_rst   (top_rst),
    .adc_mul_o (adc_mul),
    .adc_sum_o (adc_sum),
    .dac_mul_o (dac_mul),
    .dac_sum_o (dac_sum)
  );

  //////////////////////////////////////////////////////////////////////
  // Channel pipelines
  //////////////////////////////////////////////////////////////////////

  for (genvar ch = 0; ch < CHN_NUM; ch++) begin : g_chn
    // ADC side, loopback from the DAC of the same channel
    adc_frontend u_adc (
      .adc_clk    (adc_clk),
      .top_rst    (top_rst),
      .raw_i      (adc_dat_i[ch]),
      .loop_i     (loop_en),
      .loop_dat_i (dac_cal[ch]),
      .mul_i      (adc_mul[ch]),
      .sum_i      (adc_sum[ch]),
      .dat_o      (adc_dat_o[ch])
    );

    dac_backend u_dac (
      .adc_clk (adc_clk),
      .top_rst (top_rst),
      .set_i   (dac_set[ch]),
      .mul_i   (dac_mul[ch]),
      .sum_i   (dac_sum[ch]),
      .cal_o   (dac_cal[ch]),
      .raw_o   (dac_dat_o[ch])
    );
  end

endmodule : rp_top

//--- rp_top_assert.sv
// Concurrent assertions on the top-level bus handshake and DAC outputs, bound to rp_top
`timescale 1ns/1ps

module rp_top_assert (
  input logic                                                   adc_clk,
  input logic                                                   top_rst,
  input logic                                                   sys_wen_i,
  input logic                                                   sys_ren_i,
  input logic                                                   sys_ack_o,
  input logic [rp_cfg_pkg::CHN_NUM-1:0][rp_cfg_pkg::DAT_W-1:0]  dac_dat_o
);

  // Failure count, read by the testbench at the end
  int unsigned fail_cnt = 0;

  // Every strobe is answered on the next cycle
  a_strobe_ack : assert property (@(posedge adc_clk) disable iff (top_rst)
    (sys_wen_i || sys_ren_i) |=> sys_ack_o)
    else begin
      fail_cnt++;
      $error("Bus strobe not followed by ack one cycle later");
    end

  // No ack without a strobe in the cycle before
  a_ack_cause : assert property (@(posedge adc_clk) disable iff (top_rst)
    sys_ack_o |-> $past(sys_wen_i || sys_ren_i))
    else begin
      fail_cnt++;
      $error("Bus ack without a preceding strobe");
    end

  a_strobe_excl : assert property (@(posedge adc_clk) disable iff (top_rst)
    !(sys_wen_i && sys_ren_i))
    else begin
      fail_cnt++;
      $error("Write and read strobes high together");
    end

  // DAC pins fully defined once out of reset
  a_dac_known : assert property (@(posedge adc_clk) disable iff (top_rst)
    !$isunknown(dac_dat_o))
    else begin
      fail_cnt++;
      $error("Unknown bits on dac_dat_o");
    end

endmodule : rp_top_assert

bind rp_top rp_top_assert u_assert (
  .adc_clk   (adc_clk),
  .top_rst   (top_rst),
  .sys_wen_i (sys_wen_i),
  .sys_ren_i (sys_ren_i),
  .sys_ack_o (sys_ack_o),
  .dac_dat_o (dac_dat_o)
);

//--- sys_bus_decoder.sv
// System-bus region decoder with strobe routing, response mux and unmapped-region responder
`timescale 1ns/1ps

module sys_bus_decoder (
  sys_bus_if.slave  host_bus,
  sys_bus_if.master hk_bus,
  sys_bus_if.master cal_bus,
  input  logic      adc_clk,
  input  logic      top_rst
);
  import rp_bus_pkg::*;

  region_e region;
  logic    sel_hk;
  logic    sel_cal;
  logic    unm_ack;

  // Region from the field above the offset
  assign region  = region_e'(host_bus.addr[REGION_LSB +: $bits(region_e)]);
  assign sel_hk  = (region == REG_HK);
  assign sel_cal = (region == REG_CALIB);

  //////////////////////////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////////////////////////

  // Address and data broadcast, strobes only to the selected slave
  assign hk_bus.addr   = host_bus.addr;
  assign hk_bus.wdata  = host_bus.wdata;
  assign hk_bus.wen    = host_bus.wen & sel_hk;
  assign hk_bus.ren    = host_bus.ren & sel_hk;
  assign cal_bus.addr  = host_bus.addr;
  assign cal_bus.wdata = host_bus.wdata;
  assign cal_bus.wen   = host_bus.wen & sel_cal;
  assign cal_bus.ren   = host_bus.ren & sel_cal;

  // Unmapped region answers by itself one cycle later
  always_ff @(posedge adc_clk or posedge top_rst) begin
    if (top_rst) begin
      unm_ack <= 1'b0;
    end else begin
      unm_ack <= (host_bus.wen | host_bus.ren) & ~(sel_hk | sel_cal);
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////////////////////////

  // Address is held until ack, so the mux follows the live region
  always_comb begin
    case (region)
      REG_HK: begin
        host_bus.rdata = hk_bus.rdata;
        host_bus.ack   = hk_bus.ack;
        host_bus.err   = hk_bus.err;
      end
      REG_CALIB: begin
        host_bus.rdata = cal_bus.rdata;
        host_bus.ack   = cal_bus.ack;
        host_bus.err   = cal_bus.err;
      end
      default: begin
        // Unmapped, zero data with err
        host_bus.rdata = '0;
        host_bus.ack   = unm_ack;
        host_bus.err   = unm_ack;
      end
    endcase
  end

endmodule : sys_bus_decoder

//--- sys_bus_if.sv
// System-bus interface with master and slave modports
`timescale 1ns/1ps

interface sys_bus_if #(
  parameter int unsigned AW = 32, // address width
  parameter int unsigned DW = 32  // data width
);

  // Master to slave, addr and wdata held until ack
  logic [AW-1:0] addr;
  logic [DW-1:0] wdata;
  // Single-cycle strobes
  logic          wen;
  logic          ren;
  // Slave to master, valid with ack
  logic [DW-1:0] rdata;
  logic          err;
  logic          ack;

  modport master (output addr, wdata, wen, ren, input rdata, err, ack);
  modport slave  (input addr, wdata, wen, ren, output rdata, err, ack);

endinterface : sys_bus_if

//--- tb_rp_top.sv
// Testbench for rp_top with clock, reset, random bus and ADC stimulus, reference model and checks
`timescale 1ns/1ps

module tb_rp_top;
  import rp_cfg_pkg::*;
  import rp_bus_pkg::*;

  localparam int unsigned SEED = 32'haf6a_d07b;
  // About 2000 cycles of tests, three times that as limit
  localparam int MAX_CYC = 6000;
  localparam int ACK_LIMIT = 8;
  localparam int UNITY = 1 << MUL_FRAC;
  localparam int SMP_MAX = 2 ** (DAT_W - 1) - 1;
  localparam int SMP_MIN = -(2 ** (DAT_W - 1));

  logic                             adc_clk;
  logic                             top_rst;
  logic [CHN_NUM-1:0][DAT_W-1:0]    adc_dat_i;
  logic [ADDR_W-1:0]                sys_addr_i;
  logic [DATA_W-1:0]                sys_wdata_i;
  logic                             sys_wen_i;
  logic                             sys_ren_i;
  logic [DATA_W-1:0]                sys_rdata_o;
  logic                             sys_err_o;
  logic                             sys_ack_o;
  smp_t [CHN_NUM-1:0]               adc_dat_o;
  logic [CHN_NUM-1:0][DAT_W-1:0]    dac_dat_o;
  logic [LED_W-1:0]                 led_o;

  // Register model
  logic [LED_W-1:0] m_led;
  bit               m_loop;
  int               m_set [CHN_NUM];
  int               m_adc_mul [CHN_NUM];
  int               m_adc_sum [CHN_NUM];
  int               m_dac_mul [CHN_NUM];
  int               m_dac_sum [CHN_NUM];

  int chk_cnt = 0;
  int err_cnt = 0;
  int bus_err_cnt = 0;
  int cyc_cnt = 0;

  rp_top DUT (.*);

  initial begin
    adc_clk = 1'b0;
    forever #10 adc_clk = ~adc_clk;
  end

  // Run limit
  always @(posedge adc_clk) begin
    cyc_cnt++;
    if (cyc_cnt >= MAX_CYC) begin
      $display("Timeout after %0d cycles, tests did not complete", MAX_CYC);
      $display("Testbench failed");
      $finish;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Model functions
  //////////////////////////////////////////////////////////////////////

  // Gain with floor shift, offset, clamp to the sample range
  function automatic int cal_model(input int dat, input int mul, input int sum);
    longint acc;
    acc = longint'(dat) * longint'(mul);
    acc = (acc >>> MUL_FRAC) + sum;
    if (acc > SMP_MAX) return SMP_MAX;
    if (acc < SMP_MIN) return SMP_MIN;
    return int'(acc);
  endfunction

  // Negative slope raw code to signed sample
  function automatic int raw_to_smp(input logic [DAT_W-1:0] raw);
    logic signed [DAT_W-1:0] bits;
    bits = raw ^ {1'b0, {(DAT_W-1){1'b1}}};
    return bits;
  endfunction

  function automatic logic [DAT_W-1:0] smp_to_raw(input int smp);
    logic [DAT_W-1:0] bits;
    bits = smp[DAT_W-1:0];
    // Sign bit stays, the rest flips
    return bits ^ {1'b0, {(DAT_W-1){1'b1}}};
  endfunction

  function automatic logic [ADDR_W-1:0] make_addr(input logic [2:0] region,
                                                  input logic [REGION_LSB-1:0] offs);
    return ADDR_W'({region, offs});
  endfunction

  // Mostly near unity, sometimes any 16-bit value
  function automatic logic [DATA_W-1:0] rand_gain();
    if ($urandom_range(0, 2) == 0) return $urandom;
    return DATA_W'(UNITY + int'($urandom_range(0, 8191)) - 4096);
  endfunction

  task automatic check_eq(input string what, input longint got, input longint exp);
    chk_cnt++;
    assert (got == exp) else begin
      err_cnt++;
      $display("ERR %0t: %s got 0x%0h expected 0x%0h", $time, what, got, exp);
    end
  endtask

  // Expected response of one access, model updated on legal writes
  task automatic predict_access(input bit wr, input logic [ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata,
                                output logic [DATA_W-1:0] rd, output bit err);
    logic [REGION_LSB-1:0] offs;
    logic [2:0]            region;
    int                    ch;
    offs   = addr[REGION_LSB-1:0];
    region = addr[REGION_LSB +: 3];
    rd     = '0;
    err    = 1'b0;
    if (region == REG_HK) begin
      case (offs)
        HK_ID: begin
          rd  = HK_ID_VALUE;
          err = wr;
        end
        HK_LED: begin
          rd = DATA_W'(m_led);
          if (wr) m_led = wdata[LED_W-1:0];
        end
        HK_LOOP: begin
          rd = DATA_W'(m_loop);
          if (wr) m_loop = wdata[0];
        end
        HK_DAC0, HK_DAC1: begin
          ch = (offs == HK_DAC1);
          rd = m_set[ch];
          if (wr) m_set[ch] = $signed(wdata[DAT_W-1:0]);
        end
        default: err = 1'b1;
      endcase
    end else if (region == REG_CALIB) begin
      // Eight aligned words, bit 4 DAC, bit 3 channel, bit 2 offset
      if (offs[REGION_LSB-1:5] != '0 || offs[1:0] != 2'b00) begin
        err = 1'b1;
      end else begin
        ch = offs[3];
        case ({offs[4], offs[2]})
          2'b00: begin
            rd = m_adc_mul[ch];
            if (wr) m_adc_mul[ch] = $signed(wdata[MUL_W-1:0]);
          end
          2'b01: begin
            rd = m_adc_sum[ch];
            if (wr) m_adc_sum[ch] = $signed(wdata[SUM_W-1:0]);
          end
          2'b10: begin
            rd = m_dac_mul[ch];
            if (wr) m_dac_mul[ch] = $signed(wdata[MUL_W-1:0]);
          end
          default: begin
            rd = m_dac_sum[ch];
            if (wr) m_dac_sum[ch] = $signed(wdata[SUM_W-1:0]);
          end
        endcase
      end
    end else begin
      err = 1'b1;
    end
    // Failed accesses read zero
    if (err) rd = '0;
  endtask

  //////////////////////////////////////////////////////////////////////
  // Stimulus tasks
  //////////////////////////////////////////////////////////////////////

  // One strobe, wait for ack, compare with the model
  task automatic run_access(input bit wr, input logic [ADDR_W-1:0] addr,
                            input logic [DATA_W-1:0] wdata);
    logic [DATA_W-1:0] exp_rd;
    bit                exp_err;
    int                wait_cnt;
    predict_access(wr, addr, wdata, exp_rd, exp_err);
    @(negedge adc_clk);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    @(negedge adc_clk);
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    wait_cnt  = 0;
    while (!sys_ack_o && wait_cnt < ACK_LIMIT) begin
      @(negedge adc_clk);
      wait_cnt++;
    end
    assert (sys_ack_o) else begin
      bus_err_cnt++;
      $display("Bus access to address 0x%08h never got an ack", addr);
    end
    if (sys_ack_o) begin
      check_eq($sformatf("err at 0x%08h", addr), sys_err_o, exp_err);
      if (!wr) check_eq($sformatf("rdata at 0x%08h", addr), sys_rdata_o, exp_rd);
    end
    check_eq("led_o", led_o, m_led);
  endtask

  // Continuous ADC stream, output checked two cycles behind the input
  task automatic stream_adc(input int n);
    int               d1 [CHN_NUM];
    int               d2 [CHN_NUM];
    logic [DAT_W-1:0] raw;
    for (int k = 0; k < n + 2; k++) begin
      @(negedge adc_clk);
      for (int ch = 0; ch < CHN_NUM; ch++) begin
        if (k >= 2) check_eq($sformatf("adc_dat_o[%0d]", ch), $signed(adc_dat_o[ch]), d2[ch]);
        raw = DAT_W'($urandom);
        // Full scale codes now and then
        if ($urandom_range(0, 7) == 0) raw = {DAT_W{raw[0]}};
        adc_dat_i[ch] = raw;
        d2[ch] = d1[ch];
        d1[ch] = cal_model(raw_to_smp(raw), m_adc_mul[ch], m_adc_sum[ch]);
      end
    end
  endtask

  // Idle with random pins, DAC and loopback outputs checked from cycle first on
  task automatic hold_check(input int first, input int last, input bit loop_chk);
    int dac_cal;
    for (int c = 1; c <= last; c++) begin
      @(negedge adc_clk);
      for (int ch = 0; ch < CHN_NUM; ch++) begin
        adc_dat_i[ch] = DAT_W'($urandom);
        if (c >= first) begin
          dac_cal = cal_model(m_set[ch], m_dac_mul[ch], m_dac_sum[ch]);
          check_eq($sformatf("dac_dat_o[%0d]", ch), dac_dat_o[ch], smp_to_raw(dac_cal));
          if (loop_chk) begin
            check_eq($sformatf("loopback adc_dat_o[%0d]", ch), $signed(adc_dat_o[ch]),
                     cal_model(dac_cal, m_adc_mul[ch], m_adc_sum[ch]));
          end
        end
      end
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    logic [2:0]            region;
    logic [REGION_LSB-1:0] offs;
    int                    pick;
    void'($urandom(SEED));
    top_rst     = 1'b1;
    adc_dat_i   = '0;
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    // Reset values
    m_led  = '0;
    m_loop = 1'b0;
    for (int ch = 0; ch < CHN_NUM; ch++) begin
      m_set[ch]     = 0;
      m_adc_mul[ch] = UNITY;
      m_adc_sum[ch] = 0;
      m_dac_mul[ch] = UNITY;
      m_dac_sum[ch] = 0;
    end
    repeat (5) @(negedge adc_clk);
    top_rst = 1'b0;

    // Reset values through the bus, DAC at converted zero
    for (int ch = 0; ch < CHN_NUM; ch++) begin
      check_eq("dac_dat_o after reset", dac_dat_o[ch], smp_to_raw(0));
    end
    for (int i = 0; i < 5; i++) run_access(1'b0, make_addr(REG_HK, 20'(4 * i)), '0);
    for (int i = 0; i < 8; i++) run_access(1'b0, make_addr(REG_CALIB, 20'(4 * i)), '0);

    // Random register traffic, unknown offsets and unmapped regions included
    for (int i = 0; i < 150; i++) begin
      pick = $urandom_range(0, 9);
      if (pick < 4) begin
        region = REG_HK;
        offs   = 20'($urandom_range(0, 6) << 2);
      end else if (pick < 8) begin
        region = REG_CALIB;
        offs   = 20'($urandom_range(0, 9) << 2);
      end else begin
        region = 3'($urandom_range(2, 7));
        offs   = 20'($urandom_range(0, 7) << 2);
      end
      if ($urandom_range(0, 15) == 0) offs = offs + 20'd1;
      run_access(1'($urandom_range(0, 1)), make_addr(region, offs), $urandom);
    end
    run_access(1'b1, make_addr(REG_HK, HK_LOOP), '0);

    // ADC calibration, gain at 8*ch, offset at 8*ch+4
    for (int r = 0; r < 5; r++) begin
      for (int ch = 0; ch < CHN_NUM; ch++) begin
        run_access(1'b1, make_addr(REG_CALIB, 20'(8 * ch)), rand_gain());
        run_access(1'b1, make_addr(REG_CALIB, 20'(8 * ch + 4)), $urandom);
      end
      stream_adc(120);
    end

    // DAC calibration and setpoints
    for (int r = 0; r < 30; r++) begin
      for (int ch = 0; ch < CHN_NUM; ch++) begin
        if ($urandom_range(0, 1) == 1) begin
          run_access(1'b1, make_addr(REG_CALIB, 20'(16 + 8 * ch)), rand_gain());
          run_access(1'b1, make_addr(REG_CALIB, 20'(20 + 8 * ch)), $urandom);
        end
        run_access(1'b1, make_addr(REG_HK, 20'(12 + 4 * ch)), $urandom);
      end
      hold_check(2, 4, 1'b0);
    end

    // Loopback, pins ignored while enabled
    run_access(1'b1, make_addr(REG_HK, HK_LOOP), 32'd1);
    for (int r = 0; r < 30; r++) begin
      if ($urandom_range(0, 3) == 0) begin
        run_access(1'b1, make_addr(REG_CALIB, 20'(0)), rand_gain());
        run_access(1'b1, make_addr(REG_CALIB, 20'(12)), $urandom);
      end
      for (int ch = 0; ch < CHN_NUM; ch++) begin
        run_access(1'b1, make_addr(REG_HK, 20'(12 + 4 * ch)), $urandom);
      end
      hold_check(3, 5, 1'b1);
    end
    run_access(1'b1, make_addr(REG_HK, HK_LOOP), 32'd0);
    stream_adc(60);

    $display("Checks %0d, value errors %0d, bus errors %0d, assertion failures %0d",
             chk_cnt, err_cnt, bus_err_cnt, DUT.u_assert.fail_cnt);
    if (err_cnt == 0 && bus_err_cnt == 0 && DUT.u_assert.fail_cnt == 0) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule : tb_rp_top
